//--- logic/vend_pkg.sv
package vend_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // products
    ////////////////////////////////////////////////////////////////////////////

    localparam int num_products = 3;

    // credit and prices, counted in units of 100 won
    typedef logic [7:0] money_t;

    // 0 means nothing, 1 to 3 are the products
    typedef logic [1:0] item_id_t;

    typedef logic [2:0] stock_t;

    // tables are indexed by item id
    localparam money_t prod_price [1:num_products] = '{
        8'd10,
        8'd12,
        8'd15
    };

    localparam stock_t prod_init_stock [1:num_products] = '{
        3'd4,
        3'd1,
        3'd0
    };

    localparam logic [8*7-1:0] prod_name [1:num_products] = '{
        "1.Coke ",
        "2.Water",
        "3.Juice"
    };

    // leading price digits only, the line tail adds "00W"
    localparam logic [8*2-1:0] prod_price_text [1:num_products] = '{
        "10",
        "12",
        "15"
    };

    ////////////////////////////////////////////////////////////////////////////
    // coins and lcd
    ////////////////////////////////////////////////////////////////////////////

    localparam money_t coin_small = 8'd1;
    localparam money_t coin_mid   = 8'd5;
    localparam money_t coin_large = 8'd10;

    // cursor column on each lcd row
    localparam logic [6:0] ddram_top    = 7'h0d;
    localparam logic [6:0] ddram_bottom = 7'h4d;

    // one lcd row, leftmost character first
    // mark, sold flag and arrow are the last three characters
    typedef struct packed {
        logic [8*7-1:0] name;
        logic [7:0]     gap;
        logic [8*2-1:0] price;
        logic [8*3-1:0] tail;
        logic [7:0]     mark;
        logic [7:0]     sold;
        logic [7:0]     arrow;
    } lcd_fields_t;

    // flat view for the ports, field view for the formatter
    typedef union packed {
        logic [8*16-1:0] flat;
        lcd_fields_t     field;
    } lcd_line_t;

endpackage

//--- logic/product_selector.sv
module product_selector (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              up,
    input  logic                              down,
    input  logic                              select,
    input  logic                              buy,
    input  vend_pkg::money_t                  credit,
    output vend_pkg::item_id_t                window_top,
    output vend_pkg::item_id_t                selected_item,
    output logic [vend_pkg::num_products-1:0] sold_out,
    output logic [6:0]                        ddram_address,
    output logic                              sale,
    output vend_pkg::money_t                  sale_price
);
    import vend_pkg::*;

    logic [1:0] cursor;
    item_id_t   cursor_item;
    stock_t     stock [1:num_products];
    stock_t     sel_stock;
    money_t     sel_price;
    logic       buy_ok;

    // product under the cursor
    assign cursor_item = item_id_t'(cursor) + item_id_t'(1);

    // two-line window, cursor 1 keeps the row it arrived on
    always_comb begin
        case (cursor)
            2'd0: begin
                window_top = item_id_t'(1);
            end
            2'd1: begin
                if (ddram_address == ddram_bottom) begin
                    window_top = item_id_t'(1);
                end else begin
                    window_top = item_id_t'(2);
                end
            end
            default: begin
                window_top = item_id_t'(2);
            end
        endcase
    end

    // stock and price of the current selection
    always_comb begin
        sel_stock = '0;
        sel_price = '0;
        for (int i = 1; i <= num_products; i++) begin
            if (selected_item == item_id_t'(i)) begin
                sel_stock = stock[i];
                sel_price = prod_price[i];
            end
        end
    end

    // credit equal to the price is enough
    assign buy_ok = buy && (sel_stock != '0) && (credit >= sel_price);

    always_comb begin
        for (int i = 1; i <= num_products; i++) begin
            sold_out[i-1] = (stock[i] == '0);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // cursor, selection and stock
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            cursor        <= '0;
            ddram_address <= ddram_top;
            selected_item <= '0;
            sale          <= 1'b0;
            for (int i = 1; i <= num_products; i++) begin
                stock[i] <= prod_init_stock[i];
            end
        end else begin
            sale <= 1'b0;
            if (up) begin
                if (cursor != 2'd0) begin
                    cursor        <= cursor - 2'd1;
                    ddram_address <= ddram_top;
                end
            end else if (down) begin
                if (cursor != 2'd2) begin
                    cursor        <= cursor + 2'd1;
                    ddram_address <= ddram_bottom;
                end
            end else if (select) begin
                // second press on the same product deselects
                if (selected_item == cursor_item) begin
                    selected_item <= '0;
                end else if (stock[cursor_item] != '0) begin
                    selected_item <= cursor_item;
                end
            end else if (buy_ok) begin
                for (int i = 1; i <= num_products; i++) begin
                    if (selected_item == item_id_t'(i)) begin
                        stock[i] <= stock[i] - stock_t'(1);
                    end
                end
                selected_item <= '0;
                sale          <= 1'b1;
            end
        end
    end

    // price travels with the sale pulse
    always_ff @(posedge clk) begin
        if (buy_ok) begin
            sale_price <= sel_price;
        end
    end

endmodule

//--- logic/credit_ledger.sv
module credit_ledger #(
    parameter int coin_hold_cycles   = 2000000,
    parameter int refund_step_cycles = 1000000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [2:0]       coin,
    input  logic             refund,
    input  logic             sale,
    input  vend_pkg::money_t sale_price,
    output vend_pkg::money_t credit,
    output vend_pkg::money_t display_money_binary
);
    import vend_pkg::*;

    localparam int hold_w = $clog2(coin_hold_cycles + 1);
    localparam int step_w = $clog2(refund_step_cycles + 1);

    money_t            coin_val;
    money_t            coin_shown;
    money_t            credit_next;
    logic [8:0]        gross;
    logic              holding;
    logic [hold_w-1:0] hold_cnt;
    logic              refunding;
    logic [step_w-1:0] step_cnt;
    logic              step_due;

    // one-hot coin buttons, anything else counts as no coin
    always_comb begin
        case (coin)
            3'b100:  coin_val = coin_small;
            3'b010:  coin_val = coin_mid;
            3'b001:  coin_val = coin_large;
            default: coin_val = '0;
        endcase
    end

    assign step_due = refunding && (step_cnt == '0);

    ////////////////////////////////////////////////////////////////////////////
    // credit update
    ////////////////////////////////////////////////////////////////////////////

    // coin in, sale out, then one refund unit
    always_comb begin
        gross = 9'(credit) + 9'(coin_val);
        if (sale) begin
            // a refund step may have landed between approval and deduction
            if (gross >= 9'(sale_price)) begin
                gross = gross - 9'(sale_price);
            end else begin
                gross = '0;
            end
        end
        if (step_due && (gross != '0)) begin
            gross = gross - 9'd1;
        end
        credit_next = (gross > 9'd255) ? 8'hff : gross[7:0];
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            credit <= '0;
        end else begin
            credit <= credit_next;
        end
    end

    // coin value stays on the display for a while
    always_ff @(posedge clk) begin
        if (!rst) begin
            holding  <= 1'b0;
            hold_cnt <= '0;
        end else if (coin_val != '0) begin
            holding  <= 1'b1;
            hold_cnt <= hold_w'(coin_hold_cycles - 1);
        end else if (holding) begin
            if (hold_cnt == '0) begin
                holding <= 1'b0;
            end else begin
                hold_cnt <= hold_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (coin_val != '0) begin
            coin_shown <= coin_val;
        end
    end

    // refund pays out one unit per step until empty
    always_ff @(posedge clk) begin
        if (!rst) begin
            refunding <= 1'b0;
            step_cnt  <= '0;
        end else if (refund) begin
            refunding <= 1'b1;
            step_cnt  <= step_w'(refund_step_cycles - 1);
        end else if (refunding) begin
            if (credit_next == '0) begin
                refunding <= 1'b0;
            end
            if (step_due) begin
                step_cnt <= step_w'(refund_step_cycles - 1);
            end else begin
                step_cnt <= step_cnt - 1'b1;
            end
        end
    end

    assign display_money_binary = holding ? coin_shown : credit;

endmodule

//--- logic/panel_formatter.sv
module panel_formatter (
    input  logic                              clk,
    input  logic                              rst,
    input  vend_pkg::item_id_t                window_top,
    input  vend_pkg::item_id_t                selected_item,
    input  logic [vend_pkg::num_products-1:0] sold_out,
    output logic [8*16-1:0]                   line1_text,
    output logic [8*16-1:0]                   line2_text
);
    import vend_pkg::*;

    localparam logic [7:0]     char_space = 8'h20;
    localparam logic [7:0]     char_star  = 8'h2a;
    localparam logic [7:0]     char_x     = 8'h58;
    localparam logic [7:0]     char_up    = 8'h5e;
    localparam logic [7:0]     char_down  = 8'h76;
    localparam logic [8*3-1:0] tail_text  = "00W";

    lcd_line_t               line1;
    lcd_line_t               line2;
    item_id_t                bottom_item;
    logic [num_products:0]   sold_by_item;

    // fills one row for a product
    function automatic lcd_line_t build_line(
        input item_id_t   item,
        input logic       mark_on,
        input logic       sold_on,
        input logic [7:0] arrow
    );
        lcd_line_t line;
        item_id_t  idx;
        idx = (item == '0) ? item_id_t'(1) : item;
        line.field.name  = prod_name[idx];
        line.field.gap   = char_space;
        line.field.price = prod_price_text[idx];
        line.field.tail  = tail_text;
        line.field.mark  = mark_on ? char_star : char_space;
        line.field.sold  = sold_on ? char_x : char_space;
        line.field.arrow = arrow;
        return line;
    endfunction

    assign bottom_item = window_top + item_id_t'(1);

    // bit 0 stands for no product
    assign sold_by_item = {sold_out, 1'b0};

    always_ff @(posedge clk) begin
        if (!rst) begin
            line1 <= build_line(item_id_t'(1), 1'b0, prod_init_stock[1] == '0, char_up);
            line2 <= build_line(item_id_t'(2), 1'b0, prod_init_stock[2] == '0, char_down);
        end else begin
            line1 <= build_line(
                window_top,
                selected_item == window_top,
                sold_by_item[window_top],
                char_up
            );
            line2 <= build_line(
                bottom_item,
                selected_item == bottom_item,
                sold_by_item[bottom_item],
                char_down
            );
        end
    end

    assign line1_text = line1.flat;
    assign line2_text = line2.flat;

endmodule

//--- logic/vending_top.sv
module vending_top #(
    parameter int coin_hold_cycles   = 2000000,
    parameter int refund_step_cycles = 1000000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [11:0]      button_sw_oneshot,
    output vend_pkg::money_t display_money_binary,
    output logic [8*16-1:0]  line1_text,
    output logic [8*16-1:0]  line2_text,
    output logic [6:0]       ddram_address
);
    import vend_pkg::*;

    logic                    up_sw;
    logic                    down_sw;
    logic                    select_sw;
    logic [2:0]              coin_sw;
    logic                    buy_sw;
    logic                    refund_sw;
    logic                    sale;
    money_t                  sale_price;
    money_t                  credit;
    item_id_t                window_top;
    item_id_t                selected_item;
    logic [num_products-1:0] sold_out;

    ////////////////////////////////////////////////////////////////////////////
    // button decode, one event per cycle
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        up_sw     = 1'b0;
        down_sw   = 1'b0;
        select_sw = 1'b0;
        coin_sw   = '0;
        buy_sw    = 1'b0;
        refund_sw = 1'b0;
        if (button_sw_oneshot[10]) begin
            up_sw = 1'b1;
        end else if (button_sw_oneshot[4]) begin
            down_sw = 1'b1;
        end else if (button_sw_oneshot[7]) begin
            select_sw = 1'b1;
        end else if (button_sw_oneshot[2:0] != 3'b000) begin
            coin_sw = button_sw_oneshot[2:0];
        end else if (button_sw_oneshot[9]) begin
            buy_sw = 1'b1;
        end else if (button_sw_oneshot[3]) begin
            refund_sw = 1'b1;
        end
    end

    product_selector i_product_selector (
        .clk           (clk),
        .rst           (rst),
        .up            (up_sw),
        .down          (down_sw),
        .select        (select_sw),
        .buy           (buy_sw),
        .credit        (credit),
        .window_top    (window_top),
        .selected_item (selected_item),
        .sold_out      (sold_out),
        .ddram_address (ddram_address),
        .sale          (sale),
        .sale_price    (sale_price)
    );

    credit_ledger #(
        .coin_hold_cycles   (coin_hold_cycles),
        .refund_step_cycles (refund_step_cycles)
    ) i_credit_ledger (
        .clk                  (clk),
        .rst                  (rst),
        .coin                 (coin_sw),
        .refund               (refund_sw),
        .sale                 (sale),
        .sale_price           (sale_price),
        .credit               (credit),
        .display_money_binary (display_money_binary)
    );

    panel_formatter i_panel_formatter (
        .clk           (clk),
        .rst           (rst),
        .window_top    (window_top),
        .selected_item (selected_item),
        .sold_out      (sold_out),
        .line1_text    (line1_text),
        .line2_text    (line2_text)
    );

endmodule

//--- tb/vend_checker.sv
module vend_checker (
    input  logic         clk,
    input  logic         check_req,
    input  int           check_row,
    input  logic [127:0] exp_line1,
    input  logic [127:0] exp_line2,
    input  logic [7:0]   exp_money,
    input  logic [6:0]   exp_ddram,
    input  logic [127:0] line1_text,
    input  logic [127:0] line2_text,
    input  logic [7:0]   display_money_binary,
    input  logic [6:0]   ddram_address,
    output int           pass_count,
    output int           fail_count
);

    int passes = 0;
    int fails  = 0;

    // outputs are compared with the values they held before this edge
    always @(posedge clk) begin
        int errors;
        errors = 0;
        if (check_req) begin
            if (line1_text !== exp_line1) begin
                $display("FAILED t=%0t line1_text got \"%s\" expected \"%s\"",
                         $time, line1_text, exp_line1);
                errors++;
            end
            if (line2_text !== exp_line2) begin
                $display("FAILED t=%0t line2_text got \"%s\" expected \"%s\"",
                         $time, line2_text, exp_line2);
                errors++;
            end
            if (display_money_binary !== exp_money) begin
                $display("FAILED t=%0t display_money_binary got %0d expected %0d",
                         $time, display_money_binary, exp_money);
                errors++;
            end
            if (ddram_address !== exp_ddram) begin
                $display("FAILED t=%0t ddram_address got 0x%h expected 0x%h",
                         $time, ddram_address, exp_ddram);
                errors++;
            end
            if (errors == 0) begin
                passes++;
                $display("row %0d ok", check_row);
            end else begin
                fails++;
                $display("row %0d wrong in %0d outputs", check_row, errors);
            end
        end
    end

    assign pass_count = passes;
    assign fail_count = fails;

endmodule

//--- tb/tb_vending.sv
module tb_vending;

    localparam int clk_period     = 100;
    localparam int reset_cycles   = 10;
    localparam int cycles_per_row = 40;

    // button word codes, one press each
    localparam logic [11:0] btn_idle   = 12'h000;
    localparam logic [11:0] btn_up     = 12'h400;
    localparam logic [11:0] btn_down   = 12'h010;
    localparam logic [11:0] btn_select = 12'h080;
    localparam logic [11:0] btn_coin5  = 12'h002;
    localparam logic [11:0] btn_coin10 = 12'h001;
    localparam logic [11:0] btn_buy    = 12'h200;
    localparam logic [11:0] btn_return = 12'h008;

    logic         clk;
    logic         rst;
    logic [11:0]  button_sw_oneshot;
    logic [7:0]   display_money_binary;
    logic [127:0] line1_text;
    logic [127:0] line2_text;
    logic [6:0]   ddram_address;

    logic         check_req;
    int           check_row;
    logic [127:0] exp_line1;
    logic [127:0] exp_line2;
    logic [7:0]   exp_money;
    logic [6:0]   exp_ddram;
    int           pass_count;
    int           fail_count;
    logic         table_ready;

    // stimulus table, one entry per row in each queue
    logic [11:0]  code_q [$];
    int           wait_q [$];
    logic [127:0] line1_q [$];
    logic [127:0] line2_q [$];
    logic [7:0]   money_q [$];
    logic [6:0]   ddram_q [$];

    vending_top #(
        .coin_hold_cycles   (8),
        .refund_step_cycles (4)
    ) i_vending_top (
        .clk                  (clk),
        .rst                  (rst),
        .button_sw_oneshot    (button_sw_oneshot),
        .display_money_binary (display_money_binary),
        .line1_text           (line1_text),
        .line2_text           (line2_text),
        .ddram_address        (ddram_address)
    );

    vend_checker i_vend_checker (
        .clk                  (clk),
        .check_req            (check_req),
        .check_row            (check_row),
        .exp_line1            (exp_line1),
        .exp_line2            (exp_line2),
        .exp_money            (exp_money),
        .exp_ddram            (exp_ddram),
        .line1_text           (line1_text),
        .line2_text           (line2_text),
        .display_money_binary (display_money_binary),
        .ddram_address        (ddram_address),
        .pass_count           (pass_count),
        .fail_count           (fail_count)
    );

    task automatic add_row(
        input logic [11:0]  code,
        input int           wait_cycles,
        input logic [127:0] line1,
        input logic [127:0] line2,
        input logic [7:0]   money,
        input logic [6:0]   ddram
    );
        code_q.push_back(code);
        wait_q.push_back(wait_cycles);
        line1_q.push_back(line1);
        line2_q.push_back(line2);
        money_q.push_back(money);
        ddram_q.push_back(ddram);
    endtask

    task automatic build_table();
        add_row(btn_idle,   1, "1.Coke  1000W  ^", "2.Water 1200W  v", 8'd0,  7'h0d);
        // down twice, product 3 starts sold out
        add_row(btn_down,   1, "1.Coke  1000W  ^", "2.Water 1200W  v", 8'd0,  7'h4d);
        add_row(btn_down,   1, "2.Water 1200W  ^", "3.Juice 1500W Xv", 8'd0,  7'h4d);
        add_row(btn_select, 1, "2.Water 1200W  ^", "3.Juice 1500W Xv", 8'd0,  7'h4d);
        // coin value shows during the hold, then the credit
        add_row(btn_coin10, 2, "2.Water 1200W  ^", "3.Juice 1500W Xv", 8'd10, 7'h4d);
        add_row(btn_coin5,  2, "2.Water 1200W  ^", "3.Juice 1500W Xv", 8'd5,  7'h4d);
        add_row(btn_idle,   1, "2.Water 1200W  ^", "3.Juice 1500W Xv", 8'd15, 7'h4d);
        // buy product 2 for 12, its last unit
        add_row(btn_up,     1, "2.Water 1200W  ^", "3.Juice 1500W Xv", 8'd15, 7'h0d);
        add_row(btn_select, 1, "2.Water 1200W* ^", "3.Juice 1500W Xv", 8'd15, 7'h0d);
        add_row(btn_buy,    1, "2.Water 1200W X^", "3.Juice 1500W Xv", 8'd3,  7'h0d);
        // select toggle on product 1
        add_row(btn_up,     1, "1.Coke  1000W  ^", "2.Water 1200W Xv", 8'd3,  7'h0d);
        add_row(btn_select, 1, "1.Coke  1000W* ^", "2.Water 1200W Xv", 8'd3,  7'h0d);
        add_row(btn_select, 1, "1.Coke  1000W  ^", "2.Water 1200W Xv", 8'd3,  7'h0d);
        // refund has not stepped yet one cycle after the press
        add_row(btn_return, 1, "1.Coke  1000W  ^", "2.Water 1200W Xv", 8'd3,  7'h0d);
        add_row(btn_idle,   1, "1.Coke  1000W  ^", "2.Water 1200W Xv", 8'd0,  7'h0d);
        add_row(btn_idle,   4, "1.Coke  1000W  ^", "2.Water 1200W Xv", 8'd0,  7'h0d);
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        wait (table_ready);
        #((code_q.size() * cycles_per_row + reset_cycles) * clk_period);
        $display("watchdog expired before all rows were applied");
        $display("TB FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus loop
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int gap;
        rst               = 1'b0;
        button_sw_oneshot = '0;
        check_req         = 1'b0;
        check_row         = 0;
        exp_line1         = '0;
        exp_line2         = '0;
        exp_money         = '0;
        exp_ddram         = '0;
        table_ready       = 1'b0;
        void'($urandom(33));
        build_table();
        table_ready = 1'b1;

        repeat (reset_cycles) @(negedge clk);
        rst = 1'b1;

        for (int r = 0; r < code_q.size(); r++) begin
            @(negedge clk);
            button_sw_oneshot = code_q[r];
            @(negedge clk);
            button_sw_oneshot = '0;
            repeat (wait_q[r]) @(negedge clk);
            check_row = r;
            exp_line1 = line1_q[r];
            exp_line2 = line2_q[r];
            exp_money = money_q[r];
            exp_ddram = ddram_q[r];
            check_req = 1'b1;
            @(negedge clk);
            check_req = 1'b0;
            // idle long enough for the hold and any refund to finish
            gap = $urandom_range(20, 30);
            repeat (gap) @(negedge clk);
        end

        $display("rows %0d, passed %0d, failed %0d", code_q.size(), pass_count, fail_count);
        if (fail_count == 0 && pass_count == code_q.size()) begin
            $display("TB PASSED");
        end else begin
            if (pass_count + fail_count != code_q.size()) begin
                $display("not every row reached the checker");
            end
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
logic/vend_pkg.sv
logic/product_selector.sv
logic/credit_ledger.sv
logic/panel_formatter.sv
logic/vending_top.sv
tb/vend_checker.sv
tb/tb_vending.sv

//--- run_sim.sh
#!/bin/sh
# build and run the vending panel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -Mdir obj_dir \
    -f build.f --top-module tb_vending
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_vending > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# pass only when the testbench printed its pass line
if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
